//--- compile.f
logic/xgmii_rx_pkg.sv
logic/crc32_engine.sv
logic/rx_frame_delineator.sv
logic/rx_fcs_checker.sv
logic/rx_mac.sv
testbench/rx_mac_props.sv
testbench/rx_mac_tb.sv

//--- logic/crc32_engine.sv
`timescale 1ns/1ps

module crc32_engine
    import xgmii_rx_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [XGMII_DATA_W-1:0] i_data,
    input  logic [XGMII_LANES-1:0]  i_valid,
    output logic [CRC_W-1:0]        o_crc
);

    logic [CRC_W-1:0] crc_q;
    logic [CRC_W-1:0] crc_d;

    // One byte through the reflected polynomial, bit 0 first
    function automatic logic [CRC_W-1:0] crc_byte(
        input logic [CRC_W-1:0] crc_in,
        input logic [7:0]       data_in
    );
        logic [CRC_W-1:0] c;
        c = crc_in ^ {{(CRC_W-8){1'b0}}, data_in};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Fold enabled lanes in wire order, lane 0 is the earliest byte
    always_comb begin
        crc_d = crc_q;
        for (int lane = 0; lane < XGMII_LANES; lane++) begin
            if (i_valid[lane]) begin
                crc_d = crc_byte(crc_d, i_data[lane*8 +: 8]);
            end
        end
    end

    // With no lanes enabled crc_d equals crc_q, so the register holds
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            crc_q <= CRC_INIT;
        end else begin
            crc_q <= crc_d;
        end
    end

    // Unregistered result including this cycle's bytes
    assign o_crc = ~crc_d;

endmodule

//--- logic/rx_fcs_checker.sv
`timescale 1ns/1ps

module rx_fcs_checker
    import xgmii_rx_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_in_frame,
    input  logic                    i_phy_rx_valid,
    input  logic [XGMII_DATA_W-1:0] i_xgmii_rxd,
    input  logic [XGMII_DATA_W-1:0] i_beat_data,
    input  logic [XGMII_LANES-1:0]  i_beat_keep,
    input  logic                    i_term_found,
    input  logic [XGMII_LANES-1:0]  i_term_loc,
    output logic                    o_fcs_ok
);

    logic                    crc_clear;
    logic [XGMII_LANES-1:0]  valid_lanes;

    // Terminate in lanes 0..3 puts at least part of the FCS in the previous word
    logic                    term_lo;
    logic                    term_hi;
    logic [2:0]              term_idx;

    logic [XGMII_LANES-1:0]  now_excl;
    logic [XGMII_LANES-1:0]  dly_excl;
    logic [XGMII_LANES-1:0]  now_mask;
    logic [XGMII_LANES-1:0]  now_en;
    logic [XGMII_LANES-1:0]  dly_en;

    // Previous beat as seen by the current engine
    logic [XGMII_DATA_W-1:0] data_del_q;
    logic [XGMII_LANES-1:0]  mask_del_q;

    // Lanes 4..7 of the previous raw word
    logic [31:0]             prev_upper_q;
    logic [95:0]             fcs_window;
    logic [CRC_W-1:0]        fcs_rx;

    logic [CRC_W-1:0]        crc_now;
    logic [CRC_W-1:0]        crc_delayed;
    logic [CRC_W-1:0]        crc_sel;

    // Both engines restart from the init value between frames
    assign crc_clear   = i_reset || (rx_state_e'(i_in_frame) == RX_IDLE);
    assign valid_lanes = {XGMII_LANES{i_phy_rx_valid}};

    assign term_lo = |i_term_loc[3:0];
    assign term_hi = |i_term_loc[7:4];

    always_comb begin
        term_idx = '0;
        for (int lane = 0; lane < XGMII_LANES; lane++) begin
            if (i_term_loc[lane]) begin
                term_idx = 3'(lane);
            end
        end
    end

    // Lanes that hold frame data, before the four FCS bytes
    assign now_excl = {4'b0000, i_term_loc[7:4]} - 1'b1;
    assign dly_excl = {i_term_loc[3:0], 4'b0000} - 1'b1;

    always_comb begin
        if (term_hi) begin
            now_mask = i_beat_keep & now_excl;
        end else if (term_lo) begin
            now_mask = '0;
        end else begin
            now_mask = i_beat_keep;
        end
    end

    assign now_en = now_mask & valid_lanes;
    assign dly_en = (term_lo ? (mask_del_q & dly_excl) : mask_del_q) & valid_lanes;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mask_del_q <= '0;
        end else if (i_phy_rx_valid) begin
            mask_del_q <= now_mask;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_phy_rx_valid) begin
            data_del_q   <= i_beat_data;
            prev_upper_q <= i_xgmii_rxd[63:32];
        end
    end

    // FCS sits in the four byte lanes just below the terminate
    assign fcs_window = {i_xgmii_rxd, prev_upper_q};
    assign fcs_rx     = fcs_window[term_idx*8 +: 32];

    crc32_engine u_crc_now (
        .i_clk   (i_clk),
        .i_reset (crc_clear),
        .i_data  (i_beat_data),
        .i_valid (now_en),
        .o_crc   (crc_now)
    );

    crc32_engine u_crc_delayed (
        .i_clk   (i_clk),
        .i_reset (crc_clear),
        .i_data  (data_del_q),
        .i_valid (dly_en),
        .o_crc   (crc_delayed)
    );

    // Delayed engine once any FCS byte lives in the previous word
    assign crc_sel  = term_hi ? crc_now : crc_delayed;
    assign o_fcs_ok = i_term_found && (fcs_rx == crc_sel);

endmodule

//--- logic/rx_frame_delineator.sv
`timescale 1ns/1ps

module rx_frame_delineator
    import xgmii_rx_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [XGMII_DATA_W-1:0] i_xgmii_rxd,
    input  logic [XGMII_LANES-1:0]  i_xgmii_rxc,
    input  logic                    i_phy_rx_valid,
    output logic                    o_in_frame,
    output logic [XGMII_DATA_W-1:0] o_beat_data,
    output logic [XGMII_LANES-1:0]  o_beat_keep,
    output logic                    o_beat_valid,
    output logic                    o_term_found,
    output logic [XGMII_LANES-1:0]  o_term_loc
);

    localparam logic [XGMII_LANES-1:0] ALL_LANES   = '1;
    localparam logic [XGMII_LANES-1:0] UPPER_LANES = 8'hF0;

    rx_state_e state_q;
    rx_state_e state_d;

    logic in_data;
    logic start_lo;
    logic start_hi;
    logic start_found;

    // First beat after the start word and which lane the start was in
    logic first_q;
    logic start_hi_q;

    logic [XGMII_LANES-1:0] term_loc;
    logic                   term_found;
    logic [XGMII_LANES-1:0] start_keep;
    logic [XGMII_LANES-1:0] term_keep;
    logic [XGMII_LANES-1:0] keep;

    assign in_data = (state_q == RX_DATA);

    // Start code is only legal in lane 0 or lane 4
    assign start_lo = i_phy_rx_valid && i_xgmii_rxc[0] &&
                      (i_xgmii_rxd[7:0] == RS_START);
    assign start_hi = i_phy_rx_valid && i_xgmii_rxc[4] &&
                      (i_xgmii_rxd[39:32] == RS_START);
    assign start_found = !in_data && (start_lo || start_hi);

    // Terminate scan, one flag per lane
    always_comb begin
        for (int lane = 0; lane < XGMII_LANES; lane++) begin
            term_loc[lane] = in_data && i_phy_rx_valid && i_xgmii_rxc[lane] &&
                             (i_xgmii_rxd[lane*8 +: 8] == RS_TERM);
        end
    end

    assign term_found = |term_loc;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_IDLE: begin
                if (start_found) begin
                    state_d = RX_DATA;
                end
            end
            RX_DATA: begin
                if (term_found) begin
                    state_d = RX_IDLE;
                end
            end
            default: begin
                state_d = RX_IDLE;
            end
        endcase
    end

    // Everything stalls while the PHY strobe is low
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q    <= RX_IDLE;
            first_q    <= 1'b0;
            start_hi_q <= 1'b0;
        end else if (i_phy_rx_valid) begin
            state_q    <= state_d;
            first_q    <= start_found;
            start_hi_q <= start_hi;
        end
    end

    // Lane 4 start leaves only the upper half of the first beat
    assign start_keep = (first_q && start_hi_q) ? UPPER_LANES : ALL_LANES;

    // One-hot minus one gives every lane below the terminate
    assign term_keep = term_found ? (term_loc - 1'b1) : ALL_LANES;

    assign keep = in_data ? (start_keep & term_keep) : '0;

    always_comb begin
        for (int lane = 0; lane < XGMII_LANES; lane++) begin
            o_beat_data[lane*8 +: 8] = keep[lane] ? i_xgmii_rxd[lane*8 +: 8] : 8'h00;
        end
    end

    assign o_in_frame   = in_data;
    assign o_beat_keep  = keep;
    assign o_beat_valid = in_data && i_phy_rx_valid;
    assign o_term_found = term_found;
    assign o_term_loc   = term_loc;

endmodule

//--- logic/rx_mac.sv
`timescale 1ns/1ps

module rx_mac
    import xgmii_rx_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [XGMII_DATA_W-1:0] i_xgmii_rxd,
    input  logic [XGMII_LANES-1:0]  i_xgmii_rxc,
    input  logic                    i_phy_rx_valid,
    output logic [XGMII_DATA_W-1:0] o_axis_tdata,
    output logic [XGMII_LANES-1:0]  o_axis_tkeep,
    output logic                    o_axis_tvalid,
    output logic                    o_axis_tlast,
    output logic                    o_axis_tuser
);

    logic                   in_frame;
    logic                   term_found;
    logic [XGMII_LANES-1:0] term_loc;

    // Beat stream goes straight out; the terminate beat is the last beat
    rx_frame_delineator u_delineator (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii_rxd    (i_xgmii_rxd),
        .i_xgmii_rxc    (i_xgmii_rxc),
        .i_phy_rx_valid (i_phy_rx_valid),
        .o_in_frame     (in_frame),
        .o_beat_data    (o_axis_tdata),
        .o_beat_keep    (o_axis_tkeep),
        .o_beat_valid   (o_axis_tvalid),
        .o_term_found   (term_found),
        .o_term_loc     (term_loc)
    );

    assign o_axis_tlast = term_found;

    // FCS check result rides on the last beat as tuser
    rx_fcs_checker u_fcs_checker (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_in_frame     (in_frame),
        .i_phy_rx_valid (i_phy_rx_valid),
        .i_xgmii_rxd    (i_xgmii_rxd),
        .i_beat_data    (o_axis_tdata),
        .i_beat_keep    (o_axis_tkeep),
        .i_term_found   (term_found),
        .i_term_loc     (term_loc),
        .o_fcs_ok       (o_axis_tuser)
    );

endmodule

//--- logic/xgmii_rx_pkg.sv
package xgmii_rx_pkg;

    // XGMII bus geometry
    localparam int XGMII_DATA_W = 64;
    localparam int XGMII_LANES  = 8;

    // Control characters seen on a lane with its rxc bit set
    typedef enum logic [7:0] {
        RS_IDLE  = 8'h07,
        RS_START = 8'hFB,
        RS_TERM  = 8'hFD
    } xgmii_ctrl_e;

    // Receive framing state
    typedef enum logic {
        RX_IDLE = 1'b0,
        RX_DATA = 1'b1
    } rx_state_e;

    // Ethernet CRC-32, reflected form, bytes fed LSB first
    localparam int               CRC_W    = 32;
    localparam logic [CRC_W-1:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [CRC_W-1:0] CRC_POLY = 32'hEDB8_8320;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module rx_mac_tb -f compile.f -o rx_mac_sim

# The simulator status is lost in the pipe, so the log decides
./obj_dir/rx_mac_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "run_sim: simulation reported failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
echo "run_sim: simulation passed"

//--- testbench/rx_mac_props.sv
`timescale 1ns/1ps

module rx_mac_props
    import xgmii_rx_pkg::*;
(
    input logic                   i_clk,
    input logic                   i_reset,
    input logic [XGMII_LANES-1:0] i_axis_tkeep,
    input logic                   i_axis_tvalid,
    input logic                   i_axis_tlast,
    input logic                   i_axis_tuser
);

    // Last and the FCS flag only ride on a real beat
    a_last_needs_valid: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_axis_tlast |-> i_axis_tvalid
    ) else $error("o_axis_tlast high without o_axis_tvalid");

    a_user_needs_valid: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_axis_tuser |-> i_axis_tvalid
    ) else $error("o_axis_tuser high without o_axis_tvalid");

    // Only the terminate beat may carry no bytes
    a_keep_nonzero: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_axis_tvalid && !i_axis_tlast) |-> (i_axis_tkeep != '0)
    ) else $error("o_axis_tkeep is zero on a beat that is not the last");

    // First cycle out of reset is quiet
    a_quiet_after_reset: assert property (
        @(posedge i_clk)
        $fell(i_reset) |-> !(i_axis_tvalid || i_axis_tlast || i_axis_tuser)
    ) else $error("stream control outputs active in the cycle after reset");

endmodule

//--- testbench/rx_mac_tb.sv
`timescale 1ns/1ps

module rx_mac_tb
    import xgmii_rx_pkg::*;
();

    localparam int      CLK_HALF_NS      = 2;
    localparam int      RESET_CYCLES     = 8;
    localparam realtime DRIVE_DELAY      = 0.5;
    localparam int      MIN_PAYLOAD      = 60;
    localparam int      MAX_PAYLOAD      = 123;
    localparam int      NUM_TESTS        = 6;
    localparam int      TOTAL_FRAMES     = 12 + 12 + 16 + 16 + 12 + 20;
    localparam int      CYCLES_PER_FRAME = 40;
    localparam int      WATCHDOG_NS      = TOTAL_FRAMES * CYCLES_PER_FRAME * 2 * CLK_HALF_NS
                                           + RESET_CYCLES * 2 * CLK_HALF_NS + 2000;

    typedef struct packed {
        logic [XGMII_DATA_W-1:0] data;
        logic [XGMII_LANES-1:0]  keep;
        logic                    last;
        logic                    user;
    } beat_t;

    logic                    i_clk;
    logic                    i_reset;
    logic [XGMII_DATA_W-1:0] i_xgmii_rxd;
    logic [XGMII_LANES-1:0]  i_xgmii_rxc;
    logic                    i_phy_rx_valid;
    logic [XGMII_DATA_W-1:0] o_axis_tdata;
    logic [XGMII_LANES-1:0]  o_axis_tkeep;
    logic                    o_axis_tvalid;
    logic                    o_axis_tlast;
    logic                    o_axis_tuser;

    beat_t  exp_q[$];
    integer seed;
    int     error_count;
    int     beat_count;
    int     frame_count;
    bit     gaps_on;

    rx_mac dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii_rxd    (i_xgmii_rxd),
        .i_xgmii_rxc    (i_xgmii_rxc),
        .i_phy_rx_valid (i_phy_rx_valid),
        .o_axis_tdata   (o_axis_tdata),
        .o_axis_tkeep   (o_axis_tkeep),
        .o_axis_tvalid  (o_axis_tvalid),
        .o_axis_tlast   (o_axis_tlast),
        .o_axis_tuser   (o_axis_tuser)
    );

    bind rx_mac rx_mac_props u_props (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_axis_tkeep  (o_axis_tkeep),
        .i_axis_tvalid (o_axis_tvalid),
        .i_axis_tlast  (o_axis_tlast),
        .i_axis_tuser  (o_axis_tuser)
    );

    always #(CLK_HALF_NS) i_clk = ~i_clk;

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'($unsigned(r) % (hi - lo + 1));
    endfunction

    // Reflected CRC-32 taken one input bit at a time
    function automatic logic [CRC_W-1:0] next_crc(input logic [CRC_W-1:0] crc,
                                                 input logic [7:0] b);
        logic [CRC_W-1:0] c;
        logic             fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // Optional stall cycle with junk on the bus before the real word
    task automatic drive_word(input logic [XGMII_DATA_W-1:0] d,
                              input logic [XGMII_LANES-1:0] c);
        if (gaps_on && rand_range(0, 3) == 0) begin
            @(posedge i_clk);
            #(DRIVE_DELAY);
            i_phy_rx_valid = 1'b0;
            i_xgmii_rxd    = {$random(seed), $random(seed)};
            i_xgmii_rxc    = 8'($random(seed));
        end
        @(posedge i_clk);
        #(DRIVE_DELAY);
        i_xgmii_rxd    = d;
        i_xgmii_rxc    = c;
        i_phy_rx_valid = 1'b1;
    endtask

    task automatic drive_idle();
        drive_word({XGMII_LANES{8'(RS_IDLE)}}, '1);
    endtask

    task automatic send_frame(input int start_lane, input int pay_len, input bit corrupt);
        logic [7:0]              body[$];
        logic [7:0]              lane_d[$];
        logic                    lane_c[$];
        logic [CRC_W-1:0]        crc;
        logic [XGMII_DATA_W-1:0] word_d;
        logic [XGMII_LANES-1:0]  word_c;
        beat_t                   beat;
        int                      flip_pos;
        int                      first_pos;
        int                      term_pos;
        int                      pos;
        crc = CRC_INIT;
        for (int i = 0; i < pay_len; i++) begin
            body.push_back(8'(rand_range(0, 255)));
            crc = next_crc(crc, body[i]);
        end
        crc = ~crc;
        // FCS goes out least significant byte first
        for (int i = 0; i < 4; i++) begin
            body.push_back(crc[i*8 +: 8]);
        end
        if (corrupt) begin
            flip_pos = rand_range(0, pay_len * 8 + 31);
            body[flip_pos / 8] = body[flip_pos / 8] ^ (8'h01 << (flip_pos % 8));
        end

        // Lanes run as idle fill, start, preamble, SFD, body and terminate
        for (int i = 0; i < start_lane; i++) begin
            lane_d.push_back(RS_IDLE);
            lane_c.push_back(1'b1);
        end
        lane_d.push_back(RS_START);
        lane_c.push_back(1'b1);
        for (int i = 0; i < 6; i++) begin
            lane_d.push_back(8'h55);
            lane_c.push_back(1'b0);
        end
        lane_d.push_back(8'hD5);
        lane_c.push_back(1'b0);
        first_pos = lane_d.size();
        foreach (body[i]) begin
            lane_d.push_back(body[i]);
            lane_c.push_back(1'b0);
        end
        term_pos = lane_d.size();
        lane_d.push_back(RS_TERM);
        lane_c.push_back(1'b1);
        while (lane_d.size() % XGMII_LANES != 0) begin
            lane_d.push_back(RS_IDLE);
            lane_c.push_back(1'b1);
        end

        // One beat per word after the start word
        // Keep spans the body bytes only
        for (int w = 1; w <= term_pos / XGMII_LANES; w++) begin
            beat = '0;
            for (int lane = 0; lane < XGMII_LANES; lane++) begin
                pos = w * XGMII_LANES + lane;
                if (pos >= first_pos && pos < term_pos) begin
                    beat.keep[lane]          = 1'b1;
                    beat.data[lane*8 +: 8]   = lane_d[pos];
                end
            end
            beat.last = (w == term_pos / XGMII_LANES);
            beat.user = beat.last && !corrupt;
            exp_q.push_back(beat);
        end

        for (int w = 0; w < lane_d.size() / XGMII_LANES; w++) begin
            for (int lane = 0; lane < XGMII_LANES; lane++) begin
                word_d[lane*8 +: 8] = lane_d[w * XGMII_LANES + lane];
                word_c[lane]        = lane_c[w * XGMII_LANES + lane];
            end
            drive_word(word_d, word_c);
        end
        frame_count++;

        repeat (rand_range(1, 3)) begin
            drive_idle();
        end
    endtask

    // Idle until every expected beat has come out, plus a little spare
    task automatic drain();
        while (exp_q.size() != 0) begin
            drive_idle();
        end
        repeat (2) begin
            drive_idle();
        end
    endtask

    task automatic check_beat();
        beat_t exp;
        assert (exp_q.size() != 0) else begin
            $display("Output beat arrived while no frame beat was expected, data %h",
                     o_axis_tdata);
            error_count++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            beat_count++;
            assert (o_axis_tkeep === exp.keep) else begin
                $display("Mismatch o_axis_tkeep: got %h expected %h", o_axis_tkeep, exp.keep);
                error_count++;
            end
            assert (o_axis_tdata === exp.data) else begin
                $display("Mismatch o_axis_tdata: got %h expected %h", o_axis_tdata, exp.data);
                error_count++;
            end
            assert (o_axis_tlast === exp.last) else begin
                $display("Mismatch o_axis_tlast: got %h expected %h", o_axis_tlast, exp.last);
                error_count++;
            end
            assert (o_axis_tuser === exp.user) else begin
                $display("Mismatch o_axis_tuser: got %h expected %h", o_axis_tuser, exp.user);
                error_count++;
            end
        end
    endtask

    // Sample mid-cycle while the inputs are settled
    always @(negedge i_clk) begin
        if (!i_reset && o_axis_tvalid) begin
            check_beat();
        end
    end

    // A negative start_lane picks lane 0 or 4 at random
    // bad_rate 0 keeps every FCS good
    task automatic run_test(input string name, input int num_frames, input int start_lane,
                            input int bad_rate, input bit with_gaps);
        int  frames0;
        int  beats0;
        int  errors0;
        int  lane;
        bit  corrupt;
        frames0 = frame_count;
        beats0  = beat_count;
        errors0 = error_count;
        gaps_on = with_gaps;
        for (int i = 0; i < num_frames; i++) begin
            lane    = (start_lane < 0) ? 4 * rand_range(0, 1) : start_lane;
            corrupt = (bad_rate != 0) && (rand_range(0, bad_rate - 1) == 0);
            send_frame(lane, rand_range(MIN_PAYLOAD, MAX_PAYLOAD), corrupt);
        end
        drain();
        report_test(name, frames0, beats0, errors0);
    endtask

    // Payload lengths chosen so the terminate lands in every lane for both starts
    task automatic run_lane_sweep(input string name);
        int frames0;
        int beats0;
        int errors0;
        int pay_len;
        frames0 = frame_count;
        beats0  = beat_count;
        errors0 = error_count;
        gaps_on = 1'b0;
        for (int s = 0; s <= 4; s += 4) begin
            for (int lane = 0; lane < XGMII_LANES; lane++) begin
                pay_len = MIN_PAYLOAD + ((lane - s + 8) % 8) + 8 * rand_range(0, 7);
                send_frame(s, pay_len, 1'b0);
            end
        end
        drain();
        report_test(name, frames0, beats0, errors0);
    endtask

    task automatic report_test(input string name, input int frames0, input int beats0,
                               input int errors0);
        $display("Test %s finished: %0d frames, %0d beats checked, %0d errors",
                 name, frame_count - frames0, beat_count - beats0, error_count - errors0);
    endtask

    initial begin
        seed           = 32'hfb67_3e12;
        error_count    = 0;
        beat_count     = 0;
        frame_count    = 0;
        gaps_on        = 1'b0;
        i_clk          = 1'b0;
        i_reset        = 1'b1;
        // A valid start word during reset must not open a frame
        i_xgmii_rxd    = {8'hD5, {6{8'h55}}, 8'(RS_START)};
        i_xgmii_rxc    = 8'h01;
        i_phy_rx_valid = 1'b1;

        repeat (RESET_CYCLES) @(posedge i_clk);
        #(DRIVE_DELAY);
        i_reset        = 1'b0;
        i_xgmii_rxd    = {XGMII_LANES{8'(RS_IDLE)}};
        i_xgmii_rxc    = '1;

        run_test("lane0_start", 12, 0, 0, 1'b0);
        run_test("lane4_start", 12, 4, 0, 1'b0);
        run_lane_sweep("terminate_lanes");
        run_test("fcs_errors", 16, -1, 2, 1'b0);
        run_test("valid_gaps", 12, -1, 3, 1'b1);
        run_test("random_mix", 20, -1, 4, 1'b1);

        $display("Summary: %0d tests, %0d frames, %0d beats checked, %0d errors",
                 NUM_TESTS, frame_count, beat_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule
